//--- Makefile
VERILATOR = verilator
TOP       = tb_rtx_dispatch
FILELIST  = rtx_dispatch.f
FLAGS     = --binary --timing --assert -j 0
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_rtx_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rtx_dispatch;

    localparam int num_rt = 4;
    localparam int num_ic = 4;
    localparam int num_thread = 32;
    localparam int max_passes = 4;
    localparam int max_hold = 8;
    localparam int tw = rtx_dispatch_pkg::tid_w;
    localparam int watchdog_cycles = num_thread * max_passes * 200;

    // where a thread is in its life
    localparam int loc_idle = 0;
    localparam int loc_want_rt = 1;
    localparam int loc_on_rt = 2;
    localparam int loc_want_ic = 3;
    localparam int loc_on_ic = 4;
    localparam int loc_finished = 5;

    localparam int core_idle = 0;
    localparam int core_run = 1;
    localparam int core_switch = 2;

    logic clk;
    logic rst_n;
    rtx_dispatch_pkg::axi_lite_req_t axi_req;
    rtx_dispatch_pkg::axi_lite_rsp_t axi_rsp;
    logic [num_rt-1:0]             rt_switch;
    rtx_dispatch_pkg::thread_ctx_t rt_switch_ctx [num_rt];
    logic [num_rt-1:0]             rt_task_done;
    logic [num_rt-1:0]             rt_switch_ack;
    logic [num_rt-1:0]             rt_dispatch;
    rtx_dispatch_pkg::thread_ctx_t rt_ctx;
    logic [31:0]                   rt_pixel_id;
    logic [num_ic-1:0]             ic_switch;
    logic [tw-1:0]                 ic_switch_tid [num_ic];
    logic [num_ic-1:0]             ic_switch_ack;
    logic [num_ic-1:0]             ic_dispatch;
    logic [tw-1:0]                 ic_tid;
    logic                          patch_done;

    // reference model, one entry per thread
    logic [31:0] exp_pixel [num_thread];
    logic [31:0] exp_pc [num_thread];
    logic [31:0] exp_sp [num_thread];
    int          thread_loc [num_thread];
    int          passes [num_thread];
    int          target [num_thread];

    // core models
    int            rt_state [num_rt];
    int            rt_wait [num_rt];
    logic [tw-1:0] rt_thr [num_rt];
    int            ic_state [num_ic];
    int            ic_wait [num_ic];
    logic [tw-1:0] ic_thr [num_ic];

    int   errors;
    int   tests_run;
    int   tests_failed;
    int   n_loaded;
    int   n_finished;
    logic load_phase;

    rtx_dispatch_top #(
        .NUM_RT     (num_rt),
        .NUM_IC     (num_ic),
        .NUM_THREAD (num_thread)
    ) i_rtx_dispatch_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .axi_req       (axi_req),
        .axi_rsp       (axi_rsp),
        .rt_switch     (rt_switch),
        .rt_switch_ctx (rt_switch_ctx),
        .rt_task_done  (rt_task_done),
        .rt_switch_ack (rt_switch_ack),
        .rt_dispatch   (rt_dispatch),
        .rt_ctx        (rt_ctx),
        .rt_pixel_id   (rt_pixel_id),
        .ic_switch     (ic_switch),
        .ic_switch_tid (ic_switch_tid),
        .ic_switch_ack (ic_switch_ack),
        .ic_dispatch   (ic_dispatch),
        .ic_tid        (ic_tid),
        .patch_done    (patch_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // stack top: bit 31 set, thread id from bit 16
    function automatic logic [31:0] reset_sp(input int tid);
        logic [31:0] sp;
        sp = 32'h0;
        sp[31] = 1'b1;
        sp[16 +: tw] = tw'(tid);
        return sp;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        n = 0;
        axi_req.awaddr = addr;
        axi_req.wdata = data;
        axi_req.awvalid = 1'b1;
        axi_req.wvalid = 1'b1;
        @(negedge clk);
        while ((axi_rsp.awready !== 1'b1 || axi_rsp.wready !== 1'b1) && n < 50) begin
            @(negedge clk);
            n++;
        end
        // valid stays up through the handshake edge
        @(negedge clk);
        axi_req.awvalid = 1'b0;
        axi_req.wvalid = 1'b0;
        while (axi_rsp.bvalid !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (n >= 50) begin
            $display("write to %h got no response", addr);
            errors++;
        end
        resp = axi_rsp.bresp;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        axi_req.araddr = addr;
        axi_req.arvalid = 1'b1;
        @(negedge clk);
        while (axi_rsp.arready !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        axi_req.arvalid = 1'b0;
        while (axi_rsp.rvalid !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (n >= 50) begin
            $display("read from %h got no response", addr);
            errors++;
        end
        data = axi_rsp.rdata;
        resp = axi_rsp.rresp;
    endtask

    task automatic step_cores;
        logic [tw-1:0] tid;
        rt_task_done = '0;
        if (patch_done === 1'b1 && !load_phase && n_finished != n_loaded) begin
            $display("patch_done high with %0d of %0d threads finished", n_finished, n_loaded);
            errors++;
        end
        for (int i = 0; i < num_rt; i++) begin
            if (rt_dispatch[i]) begin
                tid = rt_ctx.tid;
                if (rt_state[i] != core_idle) begin
                    $display("RT core %0d dispatched while busy", i);
                    errors++;
                end
                if (thread_loc[tid] != loc_want_rt) begin
                    $display("thread %0d given to RT core %0d out of turn", tid, i);
                    errors++;
                end
                if (rt_pixel_id !== exp_pixel[tid])
                    report_mismatch("rt_pixel_id", rt_pixel_id, exp_pixel[tid]);
                if (rt_ctx.pc !== exp_pc[tid])
                    report_mismatch("rt_ctx.pc", rt_ctx.pc, exp_pc[tid]);
                if (rt_ctx.sp !== exp_sp[tid])
                    report_mismatch("rt_ctx.sp", rt_ctx.sp, exp_sp[tid]);
                thread_loc[tid] = loc_on_rt;
                rt_thr[i] = tid;
                rt_state[i] = core_run;
                rt_wait[i] = 1 + int'($urandom % max_hold);
            end else if (rt_state[i] == core_run) begin
                rt_wait[i]--;
                if (rt_wait[i] == 0) begin
                    tid = rt_thr[i];
                    passes[tid]++;
                    if (passes[tid] >= target[tid]) begin
                        rt_task_done[i] = 1'b1;
                        thread_loc[tid] = loc_finished;
                        n_finished++;
                        rt_state[i] = core_idle;
                    end else begin
                        rt_switch_ctx[i].tid = tid;
                        rt_switch_ctx[i].pc = $urandom;
                        rt_switch_ctx[i].sp = $urandom;
                        rt_switch[i] = 1'b1;
                        rt_state[i] = core_switch;
                    end
                end
            end else if (rt_state[i] == core_switch && rt_switch_ack[i]) begin
                // ctx stays on the port through the ack cycle
                tid = rt_thr[i];
                exp_pc[tid] = rt_switch_ctx[i].pc;
                exp_sp[tid] = rt_switch_ctx[i].sp;
                thread_loc[tid] = loc_want_ic;
                rt_switch[i] = 1'b0;
                rt_state[i] = core_idle;
            end
        end
        for (int i = 0; i < num_ic; i++) begin
            if (ic_dispatch[i]) begin
                tid = ic_tid;
                if (ic_state[i] != core_idle) begin
                    $display("IC core %0d dispatched while busy", i);
                    errors++;
                end
                if (thread_loc[tid] != loc_want_ic) begin
                    $display("thread %0d given to IC core %0d out of turn", tid, i);
                    errors++;
                end
                thread_loc[tid] = loc_on_ic;
                ic_thr[i] = tid;
                ic_state[i] = core_run;
                ic_wait[i] = 1 + int'($urandom % max_hold);
            end else if (ic_state[i] == core_run) begin
                ic_wait[i]--;
                if (ic_wait[i] == 0) begin
                    ic_switch_tid[i] = ic_thr[i];
                    ic_switch[i] = 1'b1;
                    ic_state[i] = core_switch;
                end
            end else if (ic_state[i] == core_switch && ic_switch_ack[i]) begin
                thread_loc[ic_thr[i]] = loc_want_rt;
                ic_switch[i] = 1'b0;
                ic_state[i] = core_idle;
            end
        end
    endtask

    task automatic load_patch(input int n);
        rtx_dispatch_pkg::cmd_word_u word;
        logic [1:0] resp;
        load_phase = 1'b1;
        word = '0;
        word.ctrl.load_start = 1'b1;
        axi_write(rtx_dispatch_pkg::reg_ctrl_addr, word, resp);
        if (resp !== 2'b00)
            report_mismatch("bresp", 32'(resp), 32'h0);
        @(negedge clk);
        if (patch_done !== 1'b0)
            report_mismatch("patch_done", 32'(patch_done), 32'h0);
        for (int t = 0; t < num_thread; t++) begin
            thread_loc[t] = loc_idle;
            passes[t] = 0;
            exp_pc[t] = 32'h0;
            exp_sp[t] = reset_sp(t);
        end
        n_finished = 0;
        n_loaded = n;
        for (int k = 0; k < n; k++) begin
            word.pixel_id = $urandom;
            exp_pixel[k] = word.pixel_id;
            target[k] = 1 + int'($urandom % max_passes);
            thread_loc[k] = loc_want_rt;
            axi_write(rtx_dispatch_pkg::reg_pixel_addr, word, resp);
            if (resp !== 2'b00)
                report_mismatch("bresp", 32'(resp), 32'h0);
        end
        word = '0;
        word.ctrl.load_done = 1'b1;
        axi_write(rtx_dispatch_pkg::reg_ctrl_addr, word, resp);
        if (resp !== 2'b00)
            report_mismatch("bresp", 32'(resp), 32'h0);
        load_phase = 1'b0;
    endtask

    task automatic run_patch(input string name, input int n);
        int first_err;
        logic [31:0] data;
        logic [1:0] resp;
        first_err = errors;
        load_patch(n);
        while (patch_done !== 1'b1)
            @(negedge clk);
        for (int t = 0; t < n; t++) begin
            if (thread_loc[t] != loc_finished) begin
                $display("thread %0d never finished", t);
                errors++;
            end
        end
        axi_read(rtx_dispatch_pkg::reg_status_addr, data, resp);
        if (resp !== 2'b00)
            report_mismatch("rresp", 32'(resp), 32'h0);
        if (data[0] !== 1'b1)
            report_mismatch("status.patch_done", 32'(data[0]), 32'h1);
        if (data[15:8] !== 8'(n))
            report_mismatch("status.loaded", 32'(data[15:8]), 32'(n));
        if (data[23:16] !== 8'(n))
            report_mismatch("status.finished", 32'(data[23:16]), 32'(n));
        end_test(name, first_err);
    endtask

    task automatic end_test(input string name, input int first_err);
        tests_run++;
        if (errors == first_err) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - first_err);
        end
    endtask

    // core side stimulus and checks
    initial begin
        rt_switch = '0;
        rt_task_done = '0;
        ic_switch = '0;
        for (int i = 0; i < num_rt; i++) begin
            rt_switch_ctx[i] = '0;
            rt_state[i] = core_idle;
        end
        for (int i = 0; i < num_ic; i++) begin
            ic_switch_tid[i] = '0;
            ic_state[i] = core_idle;
        end
        forever begin
            @(negedge clk);
            if (rst_n)
                step_cores();
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int first_err;
        logic [31:0] data;
        logic [1:0] resp;
        void'($urandom(32'ha9f6));
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        n_loaded = 0;
        n_finished = 0;
        load_phase = 1'b0;
        rst_n = 1'b0;
        axi_req = '0;
        axi_req.bready = 1'b1;
        axi_req.rready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        first_err = errors;
        axi_read(rtx_dispatch_pkg::reg_status_addr, data, resp);
        if (data !== 32'h0)
            report_mismatch("status", data, 32'h0);
        if (resp !== 2'b00)
            report_mismatch("rresp", 32'(resp), 32'h0);
        axi_write(32'h0000_0010, 32'h1, resp);
        if (resp !== 2'b10)
            report_mismatch("bresp", 32'(resp), 32'h2);
        end_test("register access", first_err);

        run_patch("full patch", num_thread);
        run_patch("second patch", 1 + int'($urandom % num_thread));

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtx_dispatch.f
src/rtx_dispatch_pkg.sv
src/dispatch_fifo.sv
src/cmd_decoder.sv
src/patch_dispatcher.sv
src/patch_status.sv
src/rtx_dispatch_top.sv
dv/tb_rtx_dispatch.sv

//--- src/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  rtx_dispatch_pkg::axi_lite_req_t axi_req,
    output rtx_dispatch_pkg::axi_lite_rsp_t axi_rsp,
    output rtx_dispatch_pkg::load_cmd_t     load_cmd,
    input  logic [31:0]                     status_word
);

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    rtx_dispatch_pkg::cmd_word_u wr_word;

    logic        wr_ready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rd_ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        wr_hit_ctrl;
    logic        wr_hit_pixel;
    logic        rd_hit_status;
    logic        rd_known;

    assign wr_word = axi_req.wdata;

    assign wr_hit_ctrl = (axi_req.awaddr == rtx_dispatch_pkg::reg_ctrl_addr);
    assign wr_hit_pixel = (axi_req.awaddr == rtx_dispatch_pkg::reg_pixel_addr);
    assign rd_hit_status = (axi_req.araddr == rtx_dispatch_pkg::reg_status_addr);
    assign rd_known = rd_hit_status
        || (axi_req.araddr == rtx_dispatch_pkg::reg_ctrl_addr)
        || (axi_req.araddr == rtx_dispatch_pkg::reg_pixel_addr);

    // write channel, aw and w taken together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= resp_okay;
            load_cmd <= '0;
        end else begin
            wr_ready <= axi_req.awvalid && axi_req.wvalid && !wr_ready && !bvalid;
            load_cmd <= '0;
            if (wr_ready) begin
                bvalid <= 1'b1;
                bresp <= (wr_hit_ctrl || wr_hit_pixel) ? resp_okay : resp_slverr;
                load_cmd.start <= wr_hit_ctrl && wr_word.ctrl.load_start;
                load_cmd.done <= wr_hit_ctrl && wr_word.ctrl.load_done;
                load_cmd.write <= wr_hit_pixel;
                load_cmd.pixel_id <= wr_word.pixel_id;
            end else if (bvalid && axi_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
            rvalid <= 1'b0;
            rresp <= resp_okay;
        end else begin
            rd_ready <= axi_req.arvalid && !rd_ready && !rvalid;
            if (rd_ready) begin
                rvalid <= 1'b1;
                rresp <= rd_known ? resp_okay : resp_slverr;
            end else if (rvalid && axi_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ready)
            rdata <= rd_hit_status ? status_word : 32'h0;
    end

    assign axi_rsp.awready = wr_ready;
    assign axi_rsp.wready = wr_ready;
    assign axi_rsp.bvalid = bvalid;
    assign axi_rsp.bresp = bresp;
    assign axi_rsp.arready = rd_ready;
    assign axi_rsp.rvalid = rvalid;
    assign axi_rsp.rdata = rdata;
    assign axi_rsp.rresp = rresp;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (axi_rsp.bvalid && !axi_req.bready) |=> (axi_rsp.bvalid && $stable(axi_rsp.bresp)));

endmodule

`default_nettype wire

//--- src/dispatch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_fifo #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 5
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    input  logic             clear
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        ptr_next = (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10: count <= count + (PTR_W+1)'(1);
                2'b01: count <= count - (PTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !clear)
            mem[wr_ptr] <= push_data;
    end

    // show-ahead read
    assign pop_data = mem[rd_ptr];
    assign empty = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || clear)
        (push && !pop) |-> (count < (PTR_W+1)'(DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || clear)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- src/patch_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module patch_dispatcher #(
    parameter int NUM_RT = 4,
    parameter int NUM_IC = 4,
    parameter int NUM_THREAD = 32,
    parameter int BIT_THREAD = rtx_dispatch_pkg::tid_w
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rtx_dispatch_pkg::load_cmd_t   load_cmd,

    input  logic [NUM_RT-1:0]             rt_switch,
    input  rtx_dispatch_pkg::thread_ctx_t rt_switch_ctx [NUM_RT],
    input  logic [NUM_RT-1:0]             rt_task_done,
    output logic [NUM_RT-1:0]             rt_switch_ack,
    output logic [NUM_RT-1:0]             rt_dispatch,
    output rtx_dispatch_pkg::thread_ctx_t rt_ctx,
    output logic [31:0]                   rt_pixel_id,

    input  logic [NUM_IC-1:0]             ic_switch,
    input  logic [BIT_THREAD-1:0]         ic_switch_tid [NUM_IC],
    output logic [NUM_IC-1:0]             ic_switch_ack,
    output logic [NUM_IC-1:0]             ic_dispatch,
    output logic [BIT_THREAD-1:0]         ic_tid
);

    logic [31:0] pixel_tab [NUM_THREAD];
    logic [31:0] pc_tab [NUM_THREAD];
    logic [31:0] sp_tab [NUM_THREAD];

    logic [BIT_THREAD:0] load_cnt;
    logic                loading;
    logic                load_wr;

    logic [NUM_RT-1:0] busy_rt;
    logic [NUM_RT-1:0] rt_req;
    logic [NUM_RT-1:0] rt_sel;
    logic [NUM_RT-1:0] rt_free;
    logic [NUM_RT-1:0] rt_pick;
    logic [NUM_IC-1:0] busy_ic;
    logic [NUM_IC-1:0] ic_req;
    logic [NUM_IC-1:0] ic_sel;
    logic [NUM_IC-1:0] ic_free;
    logic [NUM_IC-1:0] ic_pick;

    rtx_dispatch_pkg::thread_ctx_t rt_acc_ctx;
    logic [BIT_THREAD-1:0]         ic_acc_tid;

    logic                  rt_push;
    logic [BIT_THREAD-1:0] rt_push_tid;
    logic [BIT_THREAD-1:0] rt_head;
    logic                  rt_empty;
    logic                  rt_go;
    logic [BIT_THREAD-1:0] ic_head;
    logic                  ic_empty;
    logic                  ic_go;

    // pixel loading, capped at the table size
    assign load_wr = load_cmd.write && loading
        && (load_cnt < (BIT_THREAD+1)'(NUM_THREAD));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading <= 1'b0;
            load_cnt <= '0;
        end else if (load_cmd.start) begin
            loading <= 1'b1;
            load_cnt <= '0;
        end else begin
            if (load_cmd.done)
                loading <= 1'b0;
            if (load_wr)
                load_cnt <= load_cnt + (BIT_THREAD+1)'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load_wr)
            pixel_tab[load_cnt[BIT_THREAD-1:0]] <= load_cmd.pixel_id;
    end

    // saved context per thread
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_THREAD; t++) begin
                pc_tab[t] <= 32'h0;
                sp_tab[t] <= rtx_dispatch_pkg::init_sp(t[BIT_THREAD-1:0]);
            end
        end else if (load_cmd.start) begin
            for (int t = 0; t < NUM_THREAD; t++) begin
                pc_tab[t] <= 32'h0;
                sp_tab[t] <= rtx_dispatch_pkg::init_sp(t[BIT_THREAD-1:0]);
            end
        end else if (|rt_switch_ack) begin
            pc_tab[rt_acc_ctx.tid] <= rt_acc_ctx.pc;
            sp_tab[rt_acc_ctx.tid] <= rt_acc_ctx.sp;
        end
    end

    // lowest index wins; the core being acked still holds its request
    assign rt_req = rt_switch & ~rt_switch_ack;
    assign rt_sel = rt_req & (~rt_req + NUM_RT'(1));
    // no IC returns while loading, keeps the RT queue push single
    assign ic_req = ic_switch & ~ic_switch_ack & {NUM_IC{!loading}};
    assign ic_sel = ic_req & (~ic_req + NUM_IC'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_switch_ack <= '0;
            ic_switch_ack <= '0;
        end else begin
            rt_switch_ack <= rt_sel;
            ic_switch_ack <= ic_sel;
        end
    end

    always_comb begin
        rt_acc_ctx = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            if (rt_switch_ack[i])
                rt_acc_ctx = rt_switch_ctx[i];
        end
    end

    always_comb begin
        ic_acc_tid = '0;
        for (int i = 0; i < NUM_IC; i++) begin
            if (ic_switch_ack[i])
                ic_acc_tid = ic_switch_tid[i];
        end
    end

    dispatch_fifo #(
        .DEPTH(NUM_THREAD),
        .WIDTH(BIT_THREAD)
    ) i_ic_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (|rt_switch_ack),
        .push_data (rt_acc_ctx.tid),
        .pop       (ic_go),
        .pop_data  (ic_head),
        .empty     (ic_empty),
        .clear     (load_cmd.start)
    );

    assign rt_push = load_wr || (|ic_switch_ack);
    assign rt_push_tid = load_wr ? load_cnt[BIT_THREAD-1:0] : ic_acc_tid;

    dispatch_fifo #(
        .DEPTH(NUM_THREAD),
        .WIDTH(BIT_THREAD)
    ) i_rt_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rt_push),
        .push_data (rt_push_tid),
        .pop       (rt_go),
        .pop_data  (rt_head),
        .empty     (rt_empty),
        .clear     (load_cmd.start)
    );

    // dispatch to the lowest free core
    assign rt_free = ~busy_rt;
    assign rt_pick = rt_free & (~rt_free + NUM_RT'(1));
    assign rt_go = !rt_empty && !loading && (|rt_free);
    assign ic_free = ~busy_ic;
    assign ic_pick = ic_free & (~ic_free + NUM_IC'(1));
    assign ic_go = !ic_empty && (|ic_free);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_dispatch <= '0;
            ic_dispatch <= '0;
            busy_rt <= '0;
            busy_ic <= '0;
        end else begin
            rt_dispatch <= rt_pick & {NUM_RT{rt_go}};
            ic_dispatch <= ic_pick & {NUM_IC{ic_go}};
            busy_rt <= (busy_rt | (rt_pick & {NUM_RT{rt_go}})) & ~rt_switch_ack & ~rt_task_done;
            busy_ic <= (busy_ic | (ic_pick & {NUM_IC{ic_go}})) & ~ic_switch_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (rt_go) begin
            rt_ctx.tid <= rt_head;
            rt_ctx.pc <= pc_tab[rt_head];
            rt_ctx.sp <= sp_tab[rt_head];
            rt_pixel_id <= pixel_tab[rt_head];
        end
        if (ic_go)
            ic_tid <= ic_head;
    end

    // a core still asking to switch out is busy too
    a_rt_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (rt_dispatch & $past(busy_rt | rt_switch)) == '0);

    a_ic_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (ic_dispatch & $past(busy_ic | ic_switch)) == '0);

endmodule

`default_nettype wire

//--- src/patch_status.sv
`timescale 1ns/1ps
`default_nettype none

module patch_status #(
    parameter int NUM_RT = 4,
    parameter int NUM_THREAD = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rtx_dispatch_pkg::load_cmd_t load_cmd,
    input  logic [NUM_RT-1:0]           rt_task_done,
    output logic                        patch_done,
    output logic [31:0]                 status_word
);

    logic [7:0] load_cnt;
    logic [7:0] fin_cnt;
    logic [7:0] done_sum;
    logic       loading;
    logic       load_wr;

    // same cap as the pixel table
    assign load_wr = load_cmd.write && loading && (load_cnt < 8'(NUM_THREAD));

    // several cores may finish in one cycle
    always_comb begin
        done_sum = '0;
        for (int i = 0; i < NUM_RT; i++)
            done_sum = done_sum + 8'(rt_task_done[i]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading <= 1'b0;
            load_cnt <= '0;
            fin_cnt <= '0;
        end else if (load_cmd.start) begin
            loading <= 1'b1;
            load_cnt <= '0;
            fin_cnt <= '0;
        end else begin
            if (load_cmd.done)
                loading <= 1'b0;
            if (load_wr)
                load_cnt <= load_cnt + 8'd1;
            fin_cnt <= fin_cnt + done_sum;
        end
    end

    assign patch_done = (fin_cnt == load_cnt) && (load_cnt != 8'd0);
    assign status_word = {8'h00, fin_cnt, load_cnt, 7'h00, patch_done};

    a_fin_le_load: assert property (@(posedge clk) disable iff (!rst_n)
        fin_cnt <= load_cnt);

endmodule

`default_nettype wire

//--- src/rtx_dispatch_pkg.sv
`default_nettype none

package rtx_dispatch_pkg;

    localparam int tid_w = 5;

    // register offsets on the host port
    localparam logic [31:0] reg_ctrl_addr = 32'h0000_0000;
    localparam logic [31:0] reg_pixel_addr = 32'h0000_0004;
    localparam logic [31:0] reg_status_addr = 32'h0000_0008;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axi_lite_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axi_lite_rsp_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        load_done;
        logic        load_start;
    } ctrl_word_t;

    // ctrl writes and pixel writes share the data bus
    typedef union packed {
        logic [31:0] pixel_id;
        ctrl_word_t  ctrl;
    } cmd_word_u;

    typedef struct packed {
        logic [tid_w-1:0] tid;
        logic [31:0]      pc;
        logic [31:0]      sp;
    } thread_ctx_t;

    typedef struct packed {
        logic        start;
        logic        write;
        logic        done;
        logic [31:0] pixel_id;
    } load_cmd_t;

    // stack top per thread, 64 KiB apart
    function automatic logic [31:0] init_sp(input logic [tid_w-1:0] tid);
        init_sp = 32'h8000_0000 | (32'(tid) << 16);
    endfunction

endpackage

`default_nettype wire

//--- src/rtx_dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_dispatch_top #(
    parameter int NUM_RT = 4,
    parameter int NUM_IC = 4,
    parameter int NUM_THREAD = 32
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  rtx_dispatch_pkg::axi_lite_req_t       axi_req,
    output rtx_dispatch_pkg::axi_lite_rsp_t       axi_rsp,

    input  logic [NUM_RT-1:0]                     rt_switch,
    input  rtx_dispatch_pkg::thread_ctx_t         rt_switch_ctx [NUM_RT],
    input  logic [NUM_RT-1:0]                     rt_task_done,
    output logic [NUM_RT-1:0]                     rt_switch_ack,
    output logic [NUM_RT-1:0]                     rt_dispatch,
    output rtx_dispatch_pkg::thread_ctx_t         rt_ctx,
    output logic [31:0]                           rt_pixel_id,

    input  logic [NUM_IC-1:0]                     ic_switch,
    input  logic [rtx_dispatch_pkg::tid_w-1:0]    ic_switch_tid [NUM_IC],
    output logic [NUM_IC-1:0]                     ic_switch_ack,
    output logic [NUM_IC-1:0]                     ic_dispatch,
    output logic [rtx_dispatch_pkg::tid_w-1:0]    ic_tid,

    output logic                                  patch_done
);

    rtx_dispatch_pkg::load_cmd_t load_cmd;
    logic [31:0]                 status_word;

    cmd_decoder i_cmd_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .axi_req     (axi_req),
        .axi_rsp     (axi_rsp),
        .load_cmd    (load_cmd),
        .status_word (status_word)
    );

    patch_dispatcher #(
        .NUM_RT     (NUM_RT),
        .NUM_IC     (NUM_IC),
        .NUM_THREAD (NUM_THREAD),
        .BIT_THREAD (rtx_dispatch_pkg::tid_w)
    ) i_patch_dispatcher (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_cmd      (load_cmd),
        .rt_switch     (rt_switch),
        .rt_switch_ctx (rt_switch_ctx),
        .rt_task_done  (rt_task_done),
        .rt_switch_ack (rt_switch_ack),
        .rt_dispatch   (rt_dispatch),
        .rt_ctx        (rt_ctx),
        .rt_pixel_id   (rt_pixel_id),
        .ic_switch     (ic_switch),
        .ic_switch_tid (ic_switch_tid),
        .ic_switch_ack (ic_switch_ack),
        .ic_dispatch   (ic_dispatch),
        .ic_tid        (ic_tid)
    );

    patch_status #(
        .NUM_RT     (NUM_RT),
        .NUM_THREAD (NUM_THREAD)
    ) i_patch_status (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_cmd     (load_cmd),
        .rt_task_done (rt_task_done),
        .patch_done   (patch_done),
        .status_word  (status_word)
    );

endmodule

`default_nettype wire
